// File: logic/lsu_isa_pkg.sv
package lsu_isa_pkg;

   // ========================================
   // register file
   // ========================================

   localparam int REG_IDX_W = 5;

   // destination register index carried with the operation
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // ========================================
   // load/store opcodes
   // ========================================

   // loads first, then stores
   typedef enum logic [3:0] {
      LD_B  = 4'd0,
      LD_BU = 4'd1,
      LD_H  = 4'd2,
      LD_HU = 4'd3,
      LD_W  = 4'd4,
      ST_B  = 4'd5,
      ST_H  = 4'd6,
      ST_W  = 4'd7
   } lsu_op_e;

   // access width of one operation
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } acc_size_e;

endpackage

// File: logic/lsu_bus_pkg.sv
package lsu_bus_pkg;

   // general register width
   localparam int GRLEN = 32;

   // BIU data beat, two words wide
   localparam int BEAT_W = 64;
   localparam int STRB_W = BEAT_W / 8;

   typedef logic [GRLEN-1:0]  addr_t;
   typedef logic [GRLEN-1:0]  word_t;

   // one beat on the BIU data path
   typedef logic [BEAT_W-1:0] beat_t;

   // byte enables of one beat
   typedef logic [STRB_W-1:0] strb_t;

endpackage

// File: logic/lsu_issue_decode.sv
module lsu_issue_decode (
   input  lsu_isa_pkg::lsu_op_e   lsu_op,
   input  lsu_bus_pkg::addr_t     base,
   input  lsu_bus_pkg::addr_t     offset,
   output lsu_bus_pkg::addr_t     addr,
   output lsu_isa_pkg::acc_size_e acc_size,
   output logic                   is_unsigned,
   output logic                   is_store,
   output logic                   misaligned
);

   import lsu_isa_pkg::*;
   import lsu_bus_pkg::*;

   addr_t sum;

   // effective address
   assign sum  = base + offset;
   assign addr = sum;

   // opcode to size, signedness, direction
   always_comb begin
      acc_size    = SZ_WORD;
      is_unsigned = 1'b0;
      is_store    = 1'b0;
      case (lsu_op)
         LD_B: begin
            acc_size = SZ_BYTE;
         end
         LD_BU: begin
            acc_size    = SZ_BYTE;
            is_unsigned = 1'b1;
         end
         LD_H: begin
            acc_size = SZ_HALF;
         end
         LD_HU: begin
            acc_size    = SZ_HALF;
            is_unsigned = 1'b1;
         end
         LD_W: begin
            acc_size = SZ_WORD;
         end
         ST_B: begin
            acc_size = SZ_BYTE;
            is_store = 1'b1;
         end
         ST_H: begin
            acc_size = SZ_HALF;
            is_store = 1'b1;
         end
         ST_W: begin
            acc_size = SZ_WORD;
            is_store = 1'b1;
         end
         default: begin
            acc_size = SZ_WORD;
         end
      endcase
   end

   // halfword needs bit 0 clear, word needs bits 1:0 clear
   assign misaligned = ((acc_size == SZ_HALF) && sum[0]) ||
                       ((acc_size == SZ_WORD) && (sum[1:0] != 2'b00));

endmodule

// File: logic/lsu_ctrl.sv
module lsu_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   valid_e,
   input  lsu_bus_pkg::addr_t     addr_e,
   input  lsu_isa_pkg::acc_size_e acc_size_e,
   input  logic                   is_unsigned_e,
   input  logic                   is_store_e,
   input  logic                   misaligned_e,
   input  lsu_bus_pkg::word_t     wdata_e,
   input  lsu_isa_pkg::reg_idx_t  rd_e,
   input  logic                   wen_e,
   input  logic                   rd_ack,
   input  logic                   wr_ack,
   input  logic                   data_valid,
   input  logic                   write_done,
   output logic                   ready,
   output logic                   ale_e,
   output lsu_bus_pkg::addr_t     addr_m,
   output lsu_isa_pkg::acc_size_e acc_size_m,
   output logic                   is_unsigned_m,
   output lsu_bus_pkg::word_t     wdata_m,
   output logic                   rd_req,
   output logic                   wr_req,
   output logic                   finish_m,
   output lsu_isa_pkg::reg_idx_t  rd_m,
   output logic                   wen_m
);

   import lsu_isa_pkg::*;
   import lsu_bus_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_RD_REQ,
      S_RD_WAIT,
      S_WR_REQ,
      S_WR_WAIT,
      S_ALE
   } state_e;

   state_e   state;
   state_e   state_nxt;
   logic     accept;
   addr_t    addr_q;
   word_t    wdata_q;
   reg_idx_t rd_q;

   // one operation in flight, new one only from idle
   assign ready  = (state == S_IDLE);
   assign accept = valid_e & ready;

   // address error only counts with an accepted op
   assign ale_e = accept & misaligned_e;

   // ========================================
   // state machine
   // ========================================

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (accept) begin
               if (misaligned_e)
                  state_nxt = S_ALE;
               else if (is_store_e)
                  state_nxt = S_WR_REQ;
               else
                  state_nxt = S_RD_REQ;
            end
         end
         S_RD_REQ:  if (rd_ack) state_nxt = S_RD_WAIT;
         S_RD_WAIT: if (data_valid) state_nxt = S_IDLE;
         S_WR_REQ:  if (wr_ack) state_nxt = S_WR_WAIT;
         S_WR_WAIT: if (write_done) state_nxt = S_IDLE;
         // no bus traffic, finish next cycle
         S_ALE:     state_nxt = S_IDLE;
         default:   state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         state <= S_IDLE;
      else
         state <= state_nxt;
   end

   // ========================================
   // execute to memory stage capture
   // ========================================

   always_ff @(posedge clk) begin
      if (accept) begin
         addr_q        <= addr_e;
         acc_size_m    <= acc_size_e;
         is_unsigned_m <= is_unsigned_e;
         wdata_q       <= wdata_e;
         rd_q          <= rd_e;
         wen_m         <= wen_e;
      end
   end

   assign addr_m  = addr_q;
   assign wdata_m = wdata_q;
   assign rd_m    = rd_q;

   // requests held until ack, operands stay put meanwhile
   assign rd_req = (state == S_RD_REQ);
   assign wr_req = (state == S_WR_REQ);

   assign finish_m = ((state == S_RD_WAIT) & data_valid) |
                     ((state == S_WR_WAIT) & write_done) |
                     (state == S_ALE);

endmodule

// File: logic/lsu_store_format.sv
module lsu_store_format (
   input  logic [2:0]             addr_low,
   input  lsu_isa_pkg::acc_size_e acc_size,
   input  lsu_bus_pkg::word_t     wdata,
   output lsu_bus_pkg::beat_t     beat_data,
   output lsu_bus_pkg::strb_t     beat_strb
);

   import lsu_isa_pkg::*;
   import lsu_bus_pkg::*;

   word_t                   lane_data;
   logic [STRB_W/2-1:0]     lane_strb;

   // replicate narrow data so every byte lane sees it
   always_comb begin
      case (acc_size)
         SZ_BYTE: begin
            lane_data = {4{wdata[7:0]}};
            lane_strb = 4'b0001 << addr_low[1:0];
         end
         SZ_HALF: begin
            lane_data = {2{wdata[15:0]}};
            lane_strb = 4'b0011 << addr_low[1:0];
         end
         default: begin
            lane_data = wdata;
            lane_strb = 4'b1111;
         end
      endcase
   end

   // bit 2 picks the upper word of the beat
   assign beat_data = addr_low[2] ? {lane_data, {GRLEN{1'b0}}} :
                                    {{GRLEN{1'b0}}, lane_data};
   assign beat_strb = addr_low[2] ? {lane_strb, {(STRB_W/2){1'b0}}} :
                                    {{(STRB_W/2){1'b0}}, lane_strb};

endmodule

// File: logic/lsu_load_extract.sv
module lsu_load_extract (
   input  logic [2:0]             addr_low,
   input  lsu_isa_pkg::acc_size_e acc_size,
   input  logic                   is_unsigned,
   input  lsu_bus_pkg::beat_t     beat,
   output lsu_bus_pkg::word_t     result
);

   import lsu_isa_pkg::*;
   import lsu_bus_pkg::*;

   word_t       word_sel;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   logic        sign_b;
   logic        sign_h;

   // upper or lower word of the returned beat
   assign word_sel = addr_low[2] ? beat[BEAT_W-1:GRLEN] : beat[GRLEN-1:0];

   // byte at any offset, halfword at 0 or 2
   assign byte_sel = word_sel[8*addr_low[1:0] +: 8];
   assign half_sel = word_sel[16*addr_low[1] +: 16];

   // sign bits, forced to 0 for the unsigned loads
   assign sign_b = byte_sel[7] & ~is_unsigned;
   assign sign_h = half_sel[15] & ~is_unsigned;

   always_comb begin
      case (acc_size)
         SZ_BYTE: result = {{(GRLEN-8){sign_b}}, byte_sel};
         SZ_HALF: result = {{(GRLEN-16){sign_h}}, half_sel};
         default: result = word_sel;
      endcase
   end

endmodule

// File: logic/lsu_top.sv
module lsu_top (
   input  logic                  clk,
   input  logic                  rst_n,

   // pipeline, execute stage
   input  logic                  valid_e,
   input  lsu_isa_pkg::lsu_op_e  lsu_op,
   input  lsu_bus_pkg::addr_t    base,
   input  lsu_bus_pkg::addr_t    offset,
   input  lsu_bus_pkg::word_t    wdata,
   input  lsu_isa_pkg::reg_idx_t ecl_lsu_rd_e,
   input  logic                  ecl_lsu_wen_e,
   output logic                  lsu_ready,
   output logic                  lsu_ecl_ale_e,
   output lsu_bus_pkg::addr_t    lsu_csr_badv_e,

   // pipeline, memory stage
   output logic                  lsu_finish_m,
   output lsu_bus_pkg::word_t    read_result_m,
   output lsu_isa_pkg::reg_idx_t lsu_ecl_rd_m,
   output logic                  lsu_ecl_wen_m,

   // BIU read channel
   output logic                  lsu_biu_rd_req,
   output lsu_bus_pkg::addr_t    lsu_biu_rd_addr,
   input  logic                  biu_lsu_rd_ack,
   input  logic                  biu_lsu_data_valid,
   input  lsu_bus_pkg::beat_t    biu_lsu_data,

   // BIU write channel
   output logic                  lsu_biu_wr_req,
   output lsu_bus_pkg::addr_t    lsu_biu_wr_addr,
   output lsu_bus_pkg::beat_t    lsu_biu_wr_data,
   output lsu_bus_pkg::strb_t    lsu_biu_wr_strb,
   input  logic                  biu_lsu_wr_ack,
   input  logic                  biu_lsu_write_done
);

   import lsu_isa_pkg::*;
   import lsu_bus_pkg::*;

   addr_t     addr_e;
   acc_size_e dec_size;
   logic      dec_unsigned;
   logic      dec_store;
   logic      dec_misaligned;

   addr_t     addr_m;
   acc_size_e size_m;
   logic      unsigned_m;
   word_t     wdata_m;

   lsu_issue_decode u_decode (
      .lsu_op      (lsu_op),
      .base        (base),
      .offset      (offset),
      .addr        (addr_e),
      .acc_size    (dec_size),
      .is_unsigned (dec_unsigned),
      .is_store    (dec_store),
      .misaligned  (dec_misaligned)
   );

   lsu_ctrl u_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .valid_e       (valid_e),
      .addr_e        (addr_e),
      .acc_size_e    (dec_size),
      .is_unsigned_e (dec_unsigned),
      .is_store_e    (dec_store),
      .misaligned_e  (dec_misaligned),
      .wdata_e       (wdata),
      .rd_e          (ecl_lsu_rd_e),
      .wen_e         (ecl_lsu_wen_e),
      .rd_ack        (biu_lsu_rd_ack),
      .wr_ack        (biu_lsu_wr_ack),
      .data_valid    (biu_lsu_data_valid),
      .write_done    (biu_lsu_write_done),
      .ready         (lsu_ready),
      .ale_e         (lsu_ecl_ale_e),
      .addr_m        (addr_m),
      .acc_size_m    (size_m),
      .is_unsigned_m (unsigned_m),
      .wdata_m       (wdata_m),
      .rd_req        (lsu_biu_rd_req),
      .wr_req        (lsu_biu_wr_req),
      .finish_m      (lsu_finish_m),
      .rd_m          (lsu_ecl_rd_m),
      .wen_m         (lsu_ecl_wen_m)
   );

   lsu_store_format u_store_fmt (
      .addr_low  (addr_m[2:0]),
      .acc_size  (size_m),
      .wdata     (wdata_m),
      .beat_data (lsu_biu_wr_data),
      .beat_strb (lsu_biu_wr_strb)
   );

   lsu_load_extract u_load_ext (
      .addr_low    (addr_m[2:0]),
      .acc_size    (size_m),
      .is_unsigned (unsigned_m),
      .beat        (biu_lsu_data),
      .result      (read_result_m)
   );

   // both channels share the captured address
   assign lsu_biu_rd_addr = addr_m;
   assign lsu_biu_wr_addr = addr_m;
   assign lsu_csr_badv_e  = addr_e;

endmodule

// File: verif/lsu_checker.sv
module lsu_checker (
   input logic clk,
   input logic rst_n,
   input logic rd_req,
   input logic wr_req,
   input logic rd_ack,
   input logic wr_ack,
   input logic ready,
   input logic finish_m
);

   timeunit 1ns;
   timeprecision 100ps;

   // number of failed assertions so far
   int fail_count = 0;

   // ========================================
   // BIU handshake
   // ========================================

   // a request stays up until the BIU takes it
   rd_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req && !rd_ack |=> rd_req)
      else begin
         $error("read request dropped before its ack");
         fail_count++;
      end

   wr_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      wr_req && !wr_ack |=> wr_req)
      else begin
         $error("write request dropped before its ack");
         fail_count++;
      end

   one_channel: assert property (@(posedge clk) disable iff (!rst_n)
      !(rd_req && wr_req))
      else begin
         $error("read and write requests high together");
         fail_count++;
      end

   // ========================================
   // pipeline side
   // ========================================

   busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_req || wr_req) |-> !ready)
      else begin
         $error("ready high with a request pending");
         fail_count++;
      end

   finish_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      finish_m |=> !finish_m)
      else begin
         $error("finish held longer than one cycle");
         fail_count++;
      end

endmodule

bind lsu_ctrl lsu_checker u_checker (
   .clk      (clk),
   .rst_n    (rst_n),
   .rd_req   (rd_req),
   .wr_req   (wr_req),
   .rd_ack   (rd_ack),
   .wr_ack   (wr_ack),
   .ready    (ready),
   .finish_m (finish_m)
);

// File: verif/lsu_tb.sv
module lsu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import lsu_isa_pkg::*;
   import lsu_bus_pkg::*;

   localparam int          N_TESTS     = 300;
   localparam int          MEM_WORDS   = 16;
   localparam int          CLK_PERIOD  = 4;
   // gap, accept, request, ack wait, response wait, ready
   localparam int          MAX_OP_CYC  = 16;
   localparam int          WATCHDOG_NS = N_TESTS * MAX_OP_CYC * CLK_PERIOD + 1000;
   localparam logic [15:0] SEED        = 16'd22094;

   logic     clk;
   logic     rst_n;
   logic     valid_e;
   lsu_op_e  lsu_op;
   addr_t    base;
   addr_t    offset;
   word_t    wdata;
   reg_idx_t ecl_lsu_rd_e;
   logic     ecl_lsu_wen_e;
   logic     lsu_ready;
   logic     lsu_ecl_ale_e;
   addr_t    lsu_csr_badv_e;
   logic     lsu_finish_m;
   word_t    read_result_m;
   reg_idx_t lsu_ecl_rd_m;
   logic     lsu_ecl_wen_m;
   logic     lsu_biu_rd_req;
   addr_t    lsu_biu_rd_addr;
   logic     biu_lsu_rd_ack;
   logic     biu_lsu_data_valid;
   beat_t    biu_lsu_data;
   logic     lsu_biu_wr_req;
   addr_t    lsu_biu_wr_addr;
   beat_t    lsu_biu_wr_data;
   strb_t    lsu_biu_wr_strb;
   logic     biu_lsu_wr_ack;
   logic     biu_lsu_write_done;

   beat_t       mem [MEM_WORDS];
   logic [15:0] lfsr;
   int          cur_op;

   lsu_top dut0 (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("ERROR op %0d %s: expected %h, actual %h", cur_op, name, expected, actual);
         $display("Simulation finished: FAIL");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   // drive point 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   function automatic int op_bytes(input lsu_op_e op);
      case (op)
         LD_B, LD_BU, ST_B: return 1;
         LD_H, LD_HU, ST_H: return 2;
         default:           return 4;
      endcase
   endfunction

   // shift the addressed byte down to bit 0 and extend
   function automatic word_t load_model(input beat_t beat, input addr_t a, input int nbytes,
                                        input logic uns);
      beat_t sh;
      sh = beat >> (8 * a[2:0]);
      if (nbytes == 1)
         return uns ? {24'd0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
      if (nbytes == 2)
         return uns ? {16'd0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
      return sh[31:0];
   endfunction

   // ========================================
   // one operation with the testbench as BIU
   // ========================================

   task automatic run_op();
      logic [31:0] r;
      lsu_op_e     op;
      int          nbytes;
      int          ack_dly;
      int          rsp_dly;
      logic        is_st;
      logic        bad;
      addr_t       b;
      addr_t       o;
      addr_t       a;
      word_t       wd;
      reg_idx_t    rd;
      logic        wen;
      beat_t       exp_data;
      beat_t       mask;
      strb_t       exp_strb;
      take_bits(3, r);
      op     = lsu_op_e'({1'b0, r[2:0]});
      nbytes = op_bytes(op);
      is_st  = (op >= ST_B);
      take_bits(32, b);
      take_bits(12, r);
      o = {{20{r[11]}}, r[11:0]};
      // about half the time pull the address onto the access size
      take_bits(1, r);
      if (r[0])
         o = o - ((b + o) & addr_t'(nbytes - 1));
      a   = b + o;
      bad = (a & addr_t'(nbytes - 1)) != '0;
      take_bits(32, wd);
      take_bits(5, r);
      rd = r[4:0];
      take_bits(1, r);
      wen = r[0];
      take_bits(2, r);
      ack_dly = r[1:0];
      take_bits(2, r);
      rsp_dly = r[1:0];
      exp_strb = '0;
      exp_data = '0;
      mask     = '0;
      for (int j = 0; j < nbytes; j++) begin
         exp_strb[a[2:0] + j]           = 1'b1;
         exp_data[8*(a[2:0] + j) +: 8]  = wd[8*j +: 8];
         mask[8*(a[2:0] + j) +: 8]      = 8'hff;
      end
      take_bits(2, r);
      repeat (r[1:0]) next_cycle();

      next_cycle();
      valid_e       = 1'b1;
      lsu_op        = op;
      base          = b;
      offset        = o;
      wdata         = wd;
      ecl_lsu_rd_e  = rd;
      ecl_lsu_wen_e = wen;
      #1;
      check_value("ready at accept", 1, lsu_ready);
      check_value("address error flag", bad, lsu_ecl_ale_e);
      check_value("bad address", a, lsu_csr_badv_e);

      if (bad) begin
         next_cycle();
         valid_e = 1'b0;
         #1;
         check_value("finish after address error", 1, lsu_finish_m);
         check_value("no request on address error", 0, lsu_biu_rd_req | lsu_biu_wr_req);
         check_value("ready after address error", 0, lsu_ready);
      end else begin
         for (int k = 0; k <= ack_dly; k++) begin
            next_cycle();
            valid_e        = 1'b0;
            biu_lsu_rd_ack = !is_st && (k == ack_dly);
            biu_lsu_wr_ack = is_st && (k == ack_dly);
            #1;
            check_value("request held", 1, is_st ? lsu_biu_wr_req : lsu_biu_rd_req);
            check_value("other request idle", 0, is_st ? lsu_biu_rd_req : lsu_biu_wr_req);
            check_value("request address", a, is_st ? lsu_biu_wr_addr : lsu_biu_rd_addr);
            check_value("ready while requesting", 0, lsu_ready);
            if (is_st && k == ack_dly) begin
               check_value("store strobe", exp_strb, lsu_biu_wr_strb);
               check_value("store data", exp_data, lsu_biu_wr_data & mask);
               mem[a[6:3]] = (mem[a[6:3]] & ~mask) | exp_data;
            end
         end
         for (int k = 0; k <= rsp_dly; k++) begin
            next_cycle();
            biu_lsu_rd_ack     = 1'b0;
            biu_lsu_wr_ack     = 1'b0;
            biu_lsu_data_valid = !is_st && (k == rsp_dly);
            biu_lsu_write_done = is_st && (k == rsp_dly);
            biu_lsu_data       = mem[a[6:3]];
            #1;
            check_value("finish timing", k == rsp_dly, lsu_finish_m);
            check_value("request dropped after ack", 0, lsu_biu_rd_req | lsu_biu_wr_req);
            check_value("ready while waiting", 0, lsu_ready);
         end
         if (!is_st)
            check_value("load result", load_model(mem[a[6:3]], a, nbytes,
                        (op == LD_BU) || (op == LD_HU)), read_result_m);
      end
      check_value("destination register", rd, lsu_ecl_rd_m);
      check_value("write enable", wen, lsu_ecl_wen_m);

      next_cycle();
      biu_lsu_data_valid = 1'b0;
      biu_lsu_write_done = 1'b0;
      #1;
      check_value("ready after finish", 1, lsu_ready);
      check_value("finish single cycle", 0, lsu_finish_m);
   endtask

   initial begin
      clk                = 1'b0;
      rst_n              = 1'b0;
      valid_e            = 1'b0;
      lsu_op             = LD_B;
      base               = '0;
      offset             = '0;
      wdata              = '0;
      ecl_lsu_rd_e       = '0;
      ecl_lsu_wen_e      = 1'b0;
      biu_lsu_rd_ack     = 1'b0;
      biu_lsu_data_valid = 1'b0;
      biu_lsu_data       = '0;
      biu_lsu_wr_ack     = 1'b0;
      biu_lsu_write_done = 1'b0;
      lfsr               = SEED;
      cur_op             = 0;
      for (int i = 0; i < MEM_WORDS; i++)
         mem[i] = {32'h9e37_79b9 * (i + 1), ~(32'h7f4a_7c15 * i) ^ i};
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      #1;
      check_value("ready after reset", 1, lsu_ready);
      check_value("no request after reset", 0, lsu_biu_rd_req | lsu_biu_wr_req);
      check_value("no finish after reset", 0, lsu_finish_m);
      for (cur_op = 0; cur_op < N_TESTS; cur_op++)
         run_op();
      $display("Simulation finished: PASS");
      $finish;
   end

   // handshake assertions in the bound checker
   always @(dut0.u_ctrl.u_checker.fail_count) begin
      if (dut0.u_ctrl.u_checker.fail_count != 0) begin
         $display("a handshake assertion failed during operation %0d", cur_op);
         $display("Simulation finished: FAIL");
         $fatal(1, "checker assertion failed");
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: operations stopped completing within %0d ns", WATCHDOG_NS);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: lsu_top.f
logic/lsu_isa_pkg.sv
logic/lsu_bus_pkg.sv
logic/lsu_issue_decode.sv
logic/lsu_ctrl.sv
logic/lsu_store_format.sv
logic/lsu_load_extract.sv
logic/lsu_top.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - logic/lsu_isa_pkg.sv
      - logic/lsu_bus_pkg.sv
      - logic/lsu_issue_decode.sv
      - logic/lsu_ctrl.sv
      - logic/lsu_store_format.sv
      - logic/lsu_load_extract.sv
      - logic/lsu_top.sv
  - target: test
    files:
      - verif/lsu_checker.sv
      - verif/lsu_tb.sv
